/* common/fm_settings.svh */
`ifndef FM_SETTINGS_SVH
`define FM_SETTINGS_SVH

// Number of FM channels
`define FM_NUM_CH 8

// Four operators per channel
`define FM_NUM_SLOTS 32

// Timer B counts once every this many ticks
`define FM_TIMER_B_PRESCALE 16

`endif

/* common/fm_pkg.sv */
`default_nettype none

package fm_pkg;

    // Host data or address byte
    typedef logic [7:0] fm_byte_t;

    // Slot number, operator * 8 + channel
    typedef logic [4:0] fm_slot_t;

    // Global register map below 20h
    typedef enum logic [7:0] {
        ADDR_LFO_RST = 8'h01,
        ADDR_KON     = 8'h08,
        ADDR_NOISE   = 8'h0F,
        ADDR_CLKA1   = 8'h10,
        ADDR_CLKA2   = 8'h11,
        ADDR_CLKB    = 8'h12,
        ADDR_TIMER   = 8'h14,
        ADDR_LFRQ    = 8'h18,
        ADDR_PMDAMD  = 8'h19,
        ADDR_CTW     = 8'h1B
    } fm_global_addr_e;

    // Operator rows, selected by address bits 7:5
    typedef enum logic [2:0] {
        OP_DT1_MUL   = 3'd2,
        OP_TL        = 3'd3,
        OP_KS_AR     = 3'd4,
        OP_AMSEN_D1R = 3'd5,
        OP_DT2_D2R   = 3'd6,
        OP_D1L_RR    = 3'd7
    } fm_op_row_e;

    // Channel rows within 20h..3Fh, address bits 4:3
    typedef enum logic [1:0] {
        CH_RL_FB_CON = 2'd0,
        CH_KC        = 2'd1,
        CH_KF        = 2'd2,
        CH_PMS_AMS   = 2'd3
    } fm_ch_row_e;

endpackage

`default_nettype wire

/* design/fm_mmr.sv */
`default_nettype none
`timescale 1ns/100ps

module fm_mmr (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             cen,
    input  wire fm_pkg::fm_byte_t d_in,
    input  wire logic             write,
    input  wire logic             a0,
    input  wire logic             reg_busy,
    input  wire logic             committed,
    output logic                  busy,
    output logic                  ne,
    output logic [4:0]            nfrq,
    output logic [7:0]            lfo_freq,
    output logic [1:0]            lfo_w,
    output logic [6:0]            lfo_amd,
    output logic [6:0]            lfo_pmd,
    output logic                  lfo_rst,
    output logic                  ct1,
    output logic                  ct2,
    output logic [9:0]            value_a,
    output logic [7:0]            value_b,
    output logic                  load_a,
    output logic                  load_b,
    output logic                  irq_en_a,
    output logic                  irq_en_b,
    output logic                  clr_flag_a,
    output logic                  clr_flag_b,
    output logic                  wr_req,
    output fm_pkg::fm_byte_t      wr_addr,
    output fm_pkg::fm_byte_t      wr_data
);
    import fm_pkg::*;

    fm_byte_t sel_addr;
    logic     to_reg_file;

    // KON and everything from 20h up is stored per slot
    assign to_reg_file = (sel_addr >= 8'h20) || (sel_addr == ADDR_KON);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_addr   <= '0;
            busy       <= 1'b0;
            ne         <= 1'b0;
            nfrq       <= '0;
            lfo_freq   <= '0;
            lfo_w      <= '0;
            lfo_amd    <= '0;
            lfo_pmd    <= '0;
            lfo_rst    <= 1'b0;
            ct1        <= 1'b0;
            ct2        <= 1'b0;
            value_a    <= '0;
            value_b    <= '0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            irq_en_a   <= 1'b0;
            irq_en_b   <= 1'b0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            wr_req     <= 1'b0;
            wr_addr    <= '0;
            wr_data    <= '0;
        end else if (cen) begin
            if (write && !busy) begin
                busy <= 1'b1;
                if (!a0) begin
                    sel_addr <= d_in;
                end else if (to_reg_file) begin
                    // Address and data stay put until the commit
                    wr_req  <= 1'b1;
                    wr_addr <= sel_addr;
                    wr_data <= d_in;
                end else begin
                    case (sel_addr)
                        ADDR_LFO_RST: lfo_rst <= 1'b1;
                        ADDR_NOISE: begin
                            ne   <= d_in[7];
                            nfrq <= d_in[4:0];
                        end
                        ADDR_CLKA1: value_a[9:2] <= d_in;
                        ADDR_CLKA2: value_a[1:0] <= d_in[1:0];
                        ADDR_CLKB:  value_b      <= d_in;
                        ADDR_TIMER: begin
                            load_a     <= d_in[0];
                            load_b     <= d_in[1];
                            irq_en_a   <= d_in[2];
                            irq_en_b   <= d_in[3];
                            clr_flag_a <= d_in[4];
                            clr_flag_b <= d_in[5];
                        end
                        ADDR_LFRQ: lfo_freq <= d_in;
                        ADDR_PMDAMD: begin
                            // Bit 7 picks the depth being written
                            if (d_in[7]) begin
                                lfo_pmd <= d_in[6:0];
                            end else begin
                                lfo_amd <= d_in[6:0];
                            end
                        end
                        ADDR_CTW: begin
                            ct2   <= d_in[7];
                            ct1   <= d_in[6];
                            lfo_w <= d_in[1:0];
                        end
                        default: ;
                    endcase
                end
            end else begin
                // Idle tick, drop the one-shots
                lfo_rst    <= 1'b0;
                clr_flag_a <= 1'b0;
                clr_flag_b <= 1'b0;
                wr_req     <= 1'b0;
                if (committed) begin
                    busy <= 1'b0;
                end else begin
                    busy <= wr_req | reg_busy;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* fm_reg_file/fm_reg_file.sv */
`default_nettype none
`timescale 1ns/100ps
`include "fm_settings.svh"

module fm_reg_file (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             cen,
    input  wire logic             wr_req,
    input  wire fm_pkg::fm_byte_t wr_addr,
    input  wire fm_pkg::fm_byte_t wr_data,
    output logic                  reg_busy,
    output logic                  committed,
    output fm_pkg::fm_slot_t      slot_num,
    output logic [1:0]            rl,
    output logic [2:0]            fb,
    output logic [2:0]            con,
    output logic [6:0]            kc,
    output logic [5:0]            kf,
    output logic [2:0]            pms,
    output logic [1:0]            ams,
    output logic [2:0]            dt1,
    output logic [3:0]            mul,
    output logic [6:0]            tl,
    output logic [1:0]            ks,
    output logic [4:0]            ar,
    output logic                  amsen,
    output logic [4:0]            d1r,
    output logic [1:0]            dt2,
    output logic [4:0]            d2r,
    output logic [3:0]            d1l,
    output logic [3:0]            rr,
    output logic                  keyon
);
    import fm_pkg::*;

    fm_byte_t                  ch_mem [4][`FM_NUM_CH];
    fm_byte_t                  op_mem [2:7][`FM_NUM_SLOTS];
    logic [`FM_NUM_SLOTS-1:0]  kon_bits;
    logic                      pend;
    logic                      is_kon;
    logic                      is_ch;
    fm_slot_t                  target;
    logic                      hit;
    logic [2:0]                cur_ch;

    assign is_kon = (wr_addr == ADDR_KON);
    assign is_ch  = (wr_addr[7:5] == 3'b001);

    // Channel and KON writes land on the operator 0 slot
    always_comb begin
        if (is_kon) begin
            target = {2'b00, wr_data[2:0]};
        end else if (is_ch) begin
            target = {2'b00, wr_addr[2:0]};
        end else begin
            target = wr_addr[4:0];
        end
    end

    assign hit      = (wr_req || pend) && (target == slot_num);
    assign reg_busy = pend;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_num  <= '0;
            pend      <= 1'b0;
            committed <= 1'b0;
            kon_bits  <= '0;
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < `FM_NUM_CH; c++) begin
                    ch_mem[r][c] <= '0;
                end
            end
            for (int r = 2; r < 8; r++) begin
                for (int s = 0; s < `FM_NUM_SLOTS; s++) begin
                    op_mem[r][s] <= '0;
                end
            end
        end else if (cen) begin
            if (slot_num == fm_slot_t'(`FM_NUM_SLOTS - 1)) begin
                slot_num <= '0;
            end else begin
                slot_num <= slot_num + 5'd1;
            end
            committed <= 1'b0;
            if (hit) begin
                pend      <= 1'b0;
                committed <= 1'b1;
                if (is_kon) begin
                    // One key-on bit per operator, all in the same tick
                    for (int k = 0; k < 4; k++) begin
                        kon_bits[k * `FM_NUM_CH + int'(wr_data[2:0])] <= wr_data[3 + k];
                    end
                end else if (is_ch) begin
                    ch_mem[wr_addr[4:3]][wr_addr[2:0]] <= wr_data;
                end else begin
                    op_mem[wr_addr[7:5]][target] <= wr_data;
                end
            end else if (wr_req) begin
                pend <= 1'b1;
            end
        end
    end

    assign cur_ch = slot_num[2:0];

    // Channel fields, shared by the four slots of a channel
    assign rl    = ch_mem[CH_RL_FB_CON][cur_ch][7:6];
    assign fb    = ch_mem[CH_RL_FB_CON][cur_ch][5:3];
    assign con   = ch_mem[CH_RL_FB_CON][cur_ch][2:0];
    assign kc    = ch_mem[CH_KC][cur_ch][6:0];
    assign kf    = ch_mem[CH_KF][cur_ch][7:2];
    assign pms   = ch_mem[CH_PMS_AMS][cur_ch][6:4];
    assign ams   = ch_mem[CH_PMS_AMS][cur_ch][1:0];

    // Operator fields of the current slot
    assign dt1   = op_mem[OP_DT1_MUL][slot_num][6:4];
    assign mul   = op_mem[OP_DT1_MUL][slot_num][3:0];
    assign tl    = op_mem[OP_TL][slot_num][6:0];
    assign ks    = op_mem[OP_KS_AR][slot_num][7:6];
    assign ar    = op_mem[OP_KS_AR][slot_num][4:0];
    assign amsen = op_mem[OP_AMSEN_D1R][slot_num][7];
    assign d1r   = op_mem[OP_AMSEN_D1R][slot_num][4:0];
    assign dt2   = op_mem[OP_DT2_D2R][slot_num][7:6];
    assign d2r   = op_mem[OP_DT2_D2R][slot_num][4:0];
    assign d1l   = op_mem[OP_D1L_RR][slot_num][7:4];
    assign rr    = op_mem[OP_D1L_RR][slot_num][3:0];
    assign keyon = kon_bits[slot_num];

endmodule

`default_nettype wire

/* design/fm_timers.sv */
`default_nettype none
`timescale 1ns/100ps
`include "fm_settings.svh"

module fm_timers (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       cen,
    input  wire logic [9:0] value_a,
    input  wire logic [7:0] value_b,
    input  wire logic       load_a,
    input  wire logic       load_b,
    input  wire logic       irq_en_a,
    input  wire logic       irq_en_b,
    input  wire logic       clr_flag_a,
    input  wire logic       clr_flag_b,
    output logic            flag_a,
    output logic            flag_b,
    output logic            irq_n
);
    localparam int PRE_W = $clog2(`FM_TIMER_B_PRESCALE);

    logic [9:0]       cnt_a;
    logic [7:0]       cnt_b;
    logic [PRE_W-1:0] pre_b;

    // Timer A, one step per tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_a  <= '0;
            flag_a <= 1'b0;
        end else if (cen) begin
            if (clr_flag_a) begin
                flag_a <= 1'b0;
            end
            if (!load_a) begin
                // Stopped, keep the start value ready
                cnt_a <= value_a;
            end else if (cnt_a == 10'h3FF) begin
                cnt_a <= value_a;
                if (irq_en_a) begin
                    flag_a <= 1'b1;
                end
            end else begin
                cnt_a <= cnt_a + 10'd1;
            end
        end
    end

    // Timer B, stepped through the prescaler
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_b  <= '0;
            pre_b  <= '0;
            flag_b <= 1'b0;
        end else if (cen) begin
            if (clr_flag_b) begin
                flag_b <= 1'b0;
            end
            if (!load_b) begin
                cnt_b <= value_b;
                pre_b <= '0;
            end else if (pre_b == PRE_W'(`FM_TIMER_B_PRESCALE - 1)) begin
                pre_b <= '0;
                if (cnt_b == 8'hFF) begin
                    cnt_b <= value_b;
                    if (irq_en_b) begin
                        flag_b <= 1'b1;
                    end
                end else begin
                    cnt_b <= cnt_b + 8'd1;
                end
            end else begin
                pre_b <= pre_b + 1'b1;
            end
        end
    end

    assign irq_n = ~(flag_a | flag_b);

endmodule

`default_nettype wire

/* design/fm_regs_top.sv */
`default_nettype none
`timescale 1ns/100ps

module fm_regs_top (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             cen,
    input  wire fm_pkg::fm_byte_t d_in,
    input  wire logic             write,
    input  wire logic             a0,
    output wire logic             busy,
    output wire logic [2:0]       status,
    output wire logic             ne,
    output wire logic [4:0]       nfrq,
    output wire logic [7:0]       lfo_freq,
    output wire logic [1:0]       lfo_w,
    output wire logic [6:0]       lfo_amd,
    output wire logic [6:0]       lfo_pmd,
    output wire logic             lfo_rst,
    output wire logic             ct1,
    output wire logic             ct2,
    output wire logic             flag_a,
    output wire logic             flag_b,
    output wire logic             irq_n,
    output wire fm_pkg::fm_slot_t slot_num,
    output wire logic [1:0]       rl,
    output wire logic [2:0]       fb,
    output wire logic [2:0]       con,
    output wire logic [6:0]       kc,
    output wire logic [5:0]       kf,
    output wire logic [2:0]       pms,
    output wire logic [1:0]       ams,
    output wire logic [2:0]       dt1,
    output wire logic [3:0]       mul,
    output wire logic [6:0]       tl,
    output wire logic [1:0]       ks,
    output wire logic [4:0]       ar,
    output wire logic             amsen,
    output wire logic [4:0]       d1r,
    output wire logic [1:0]       dt2,
    output wire logic [4:0]       d2r,
    output wire logic [3:0]       d1l,
    output wire logic [3:0]       rr,
    output wire logic             keyon
);
    import fm_pkg::*;

    // Decoder to register file
    wire logic     wr_req;
    wire fm_byte_t wr_addr;
    wire fm_byte_t wr_data;
    wire logic     reg_busy;
    wire logic     committed;

    // Decoder to timers
    wire logic [9:0] value_a;
    wire logic [7:0] value_b;
    wire logic       load_a;
    wire logic       load_b;
    wire logic       irq_en_a;
    wire logic       irq_en_b;
    wire logic       clr_flag_a;
    wire logic       clr_flag_b;

    fm_mmr u_fm_mmr (.*);

    fm_reg_file u_fm_reg_file (.*);

    fm_timers u_fm_timers (.*);

    // Host status byte, low three bits
    assign status = {busy, flag_b, flag_a};

endmodule

`default_nettype wire

/* test/tb_fm_regs.sv */
`default_nettype none
`timescale 1ns/100ps
`include "fm_settings.svh"

module tb_fm_regs;
    import fm_pkg::*;

    // Several times the longest expected run
    localparam int MAX_CYCLES = 20000;

    logic             clk;
    logic             rst;
    logic             cen;
    fm_byte_t         d_in;
    logic             write;
    logic             a0;
    logic             busy, ne, lfo_rst, ct1, ct2, flag_a, flag_b, irq_n;
    logic [2:0]       status;
    logic [4:0]       nfrq;
    logic [7:0]       lfo_freq;
    logic [1:0]       lfo_w;
    logic [6:0]       lfo_amd, lfo_pmd;
    fm_slot_t         slot_num;
    logic [1:0]       rl, ams, ks, dt2;
    logic [2:0]       fb, con, pms, dt1;
    logic [6:0]       kc, tl;
    logic [5:0]       kf;
    logic [3:0]       mul, d1l, rr;
    logic [4:0]       ar, d1r, d2r;
    logic             amsen, keyon;

    // Reference model of the stored bytes and global outputs
    fm_byte_t                 exp_ch [4][`FM_NUM_CH];
    fm_byte_t                 exp_op [2:7][`FM_NUM_SLOTS];
    logic [`FM_NUM_SLOTS-1:0] exp_kon;
    logic                     exp_ne, exp_lfo_rst, exp_ct1, exp_ct2;
    logic [4:0]               exp_nfrq;
    logic [7:0]               exp_lfo_freq;
    logic [1:0]               exp_lfo_w;
    logic [6:0]               exp_amd, exp_pmd;
    fm_slot_t                 exp_slot;

    // Timer flags as {B, A}
    logic [1:0]               exp_flags;

    logic [15:0] lfsr;
    int          cen_phase;
    int          tick_cnt;
    int          cycle_cnt;
    int          last_accept;
    int          watch_start, watch_limit;
    logic [1:0]  watch_mask;
    logic        idle_chk;

    wire [68:0] dut_fields = {rl, fb, con, kc, kf, pms, ams, dt1, mul, tl, ks, ar,
                              amsen, d1r, dt2, d2r, d1l, rr, keyon};
    wire [32:0] dut_globals = {ne, nfrq, lfo_freq, lfo_w, lfo_amd, lfo_pmd, ct1, ct2, lfo_rst};

    fm_regs_top u_fm_regs_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Clock enable, two ticks out of every three cycles
    initial begin
        cen       = 1'b0;
        cen_phase = 0;
        forever begin
            @(negedge clk);
            cen_phase = (cen_phase == 2) ? 0 : cen_phase + 1;
            cen       = (cen_phase != 2);
        end
    end

    // Slot sequence steps once per tick and wraps after the last slot
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= 0;
            exp_slot <= '0;
        end else if (cen) begin
            tick_cnt <= tick_cnt + 1;
            exp_slot <= exp_slot + 5'd1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout, the run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    task automatic abort_run(input string text);
        $display("%s", text);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("ERROR at %0d ns: %s", $time, msg));
    endtask

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        logic       fb_bit;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb_bit = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr   = {lfsr[14:0], fb_bit};
            r      = {r[6:0], fb_bit};
        end
        return r;
    endfunction

    // Slot fields from the model, channel is the slot number mod 8
    function automatic logic [68:0] expected_fields(input logic [4:0] s);
        fm_byte_t c0, c1, c2, c3;
        c0 = exp_ch[0][s[2:0]];
        c1 = exp_ch[1][s[2:0]];
        c2 = exp_ch[2][s[2:0]];
        c3 = exp_ch[3][s[2:0]];
        return {c0[7:6], c0[5:3], c0[2:0], c1[6:0], c2[7:2], c3[6:4], c3[1:0],
                exp_op[2][s][6:4], exp_op[2][s][3:0], exp_op[3][s][6:0],
                exp_op[4][s][7:6], exp_op[4][s][4:0], exp_op[5][s][7], exp_op[5][s][4:0],
                exp_op[6][s][7:6], exp_op[6][s][4:0], exp_op[7][s][7:4], exp_op[7][s][3:0],
                exp_kon[s]};
    endfunction

    assert property (@(posedge clk) disable iff (rst) slot_num == exp_slot)
        else value_error("slot_num out of sequence");
    assert property (@(posedge clk) disable iff (rst) dut_fields == expected_fields(slot_num))
        else value_error($sformatf("slot %0d fields differ from the model", slot_num));
    assert property (@(posedge clk) disable iff (rst)
        dut_globals == {exp_ne, exp_nfrq, exp_lfo_freq, exp_lfo_w, exp_amd, exp_pmd,
                        exp_ct1, exp_ct2, exp_lfo_rst})
        else value_error("global register outputs differ from the model");
    // A flag bit still being waited for may take either value
    assert property (@(posedge clk) disable iff (rst)
        status[2] == busy && ((status[1:0] ^ exp_flags) & ~watch_mask) == 2'b00)
        else value_error("status does not match busy and the timer flags");
    assert property (@(posedge clk) disable iff (rst)
        (irq_n == (exp_flags == 2'b00)) || (watch_mask != 2'b00 && !irq_n))
        else value_error("irq_n does not follow the timer flags");
    assert property (@(posedge clk) disable iff (rst) !(idle_chk && (busy || lfo_rst || !irq_n)))
        else value_error("busy, lfo_rst or irq_n wrong after reset");
    assert property (@(posedge clk) disable iff (rst)
        !(watch_mask != 2'b00 && (tick_cnt - watch_start >= watch_limit)))
        else value_error($sformatf("timer flag not set within %0d ticks", watch_limit));

    // Present one host write, held for a single cen tick
    task automatic drive_host(input logic is_data, input fm_byte_t val);
        a0    = is_data;
        d_in  = val;
        write = 1'b1;
        @(posedge clk);
        while (!cen) @(posedge clk);
        @(negedge clk);
        write = 1'b0;
    endtask

    task automatic wait_not_busy();
        while (busy) @(negedge clk);
    endtask

    task automatic wait_ticks(input int n);
        int start;
        start = tick_cnt;
        while (tick_cnt - start < n) @(negedge clk);
    endtask

    // Address then data, with an optional extra write while busy
    task automatic write_reg(input fm_byte_t addr, input fm_byte_t data, input logic stray);
        drive_host(1'b0, addr);
        wait_not_busy();
        drive_host(1'b1, data);
        last_accept = tick_cnt;
        case (addr)
            ADDR_LFO_RST: exp_lfo_rst = 1'b1;
            ADDR_NOISE: begin
                exp_ne   = data[7];
                exp_nfrq = data[4:0];
            end
            ADDR_LFRQ: exp_lfo_freq = data;
            ADDR_PMDAMD: begin
                if (data[7]) begin
                    exp_pmd = data[6:0];
                end else begin
                    exp_amd = data[6:0];
                end
            end
            ADDR_CTW: begin
                exp_ct2   = data[7];
                exp_ct1   = data[6];
                exp_lfo_w = data[1:0];
            end
            default: ;
        endcase
        if (stray) begin
            drive_host(1'b1, ~data);
        end
        wait_not_busy();
        exp_lfo_rst = 1'b0;
        if (addr == ADDR_KON) begin
            for (int k = 0; k < 4; k++) begin
                exp_kon[k * `FM_NUM_CH + int'(data[2:0])] = data[3 + k];
            end
        end else if (addr[7:5] == 3'b001) begin
            exp_ch[addr[4:3]][addr[2:0]] = data;
        end else if (addr >= 8'h20) begin
            exp_op[addr[7:5]][addr[4:0]] = data;
        end else if (addr == ADDR_TIMER) begin
            // Clear bits take effect on the tick busy falls
            exp_flags = exp_flags & ~data[5:4];
        end
    endtask

    // Wait for a status flag bit, counted from the last accepted data write
    task automatic expect_flag(input int bit_idx, input int limit);
        watch_start = last_accept;
        watch_limit = limit;
        watch_mask  = 2'b01 << bit_idx;
        while (!status[bit_idx]) @(negedge clk);
        watch_mask = 2'b00;
        exp_flags[bit_idx] = 1'b1;
    endtask

    initial begin
        fm_byte_t   addr;
        logic [7:0] row;
        logic [7:0] low;
        logic [7:0] val;
        int         vb;
        rst   = 1'b1;
        write = 1'b0;
        a0    = 1'b0;
        d_in  = '0;
        lfsr  = 16'd65;
        cycle_cnt = 0;
        last_accept = 0;
        watch_start = 0;
        watch_limit = 0;
        watch_mask  = 2'b00;
        exp_flags   = 2'b00;
        idle_chk    = 1'b0;
        {exp_ne, exp_lfo_rst, exp_ct1, exp_ct2, exp_nfrq, exp_lfo_freq} = '0;
        {exp_lfo_w, exp_amd, exp_pmd, exp_kon} = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < `FM_NUM_CH; c++) begin
                exp_ch[r][c] = '0;
            end
        end
        for (int r = 2; r < 8; r++) begin
            for (int s = 0; s < `FM_NUM_SLOTS; s++) begin
                exp_op[r][s] = '0;
            end
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Quiet outputs and zero fields over a full sweep
        idle_chk = 1'b1;
        wait_ticks(`FM_NUM_SLOTS + 2);
        idle_chk = 1'b0;

        write_reg(ADDR_NOISE, rand_bits(8), 1'b0);
        write_reg(ADDR_LFRQ, rand_bits(8), 1'b1);
        val = rand_bits(7);
        write_reg(ADDR_PMDAMD, {1'b0, val[6:0]}, 1'b0);
        val = rand_bits(7);
        write_reg(ADDR_PMDAMD, {1'b1, val[6:0]}, 1'b1);
        write_reg(ADDR_CTW, rand_bits(8), 1'b0);
        write_reg(ADDR_LFO_RST, rand_bits(8), 1'b0);

        // Random channel and operator bytes, every fourth with a dropped write
        for (int i = 0; i < 48; i++) begin
            row = rand_bits(3);
            low = rand_bits(5);
            if (row >= 8'd2) begin
                addr = {row[2:0], low[4:0]};
            end else begin
                addr = {3'b001, low[4:0]};
            end
            write_reg(addr, rand_bits(8), (i % 4) == 3);
        end

        for (int i = 0; i < 12; i++) begin
            write_reg(ADDR_KON, rand_bits(8), (i % 3) == 1);
        end
        wait_ticks(2 * `FM_NUM_SLOTS);

        // Timer A from 1020 with its interrupt on
        write_reg(ADDR_CLKA1, 8'hFF, 1'b0);
        write_reg(ADDR_CLKA2, 8'h00, 1'b0);
        write_reg(ADDR_TIMER, 8'h05, 1'b0);
        expect_flag(0, 8);
        // irq_n back high once flag A is cleared
        write_reg(ADDR_TIMER, 8'h10, 1'b0);
        wait_ticks(8);

        val = rand_bits(4);
        vb  = 240 + int'(val[3:0]);
        write_reg(ADDR_CLKB, fm_byte_t'(vb), 1'b0);
        write_reg(ADDR_TIMER, 8'h0A, 1'b0);
        expect_flag(1, `FM_TIMER_B_PRESCALE * (256 - vb));
        write_reg(ADDR_TIMER, 8'h0F, 1'b0);
        expect_flag(0, 8);
        // Both flags now held in status
        wait_ticks(4);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/fm_pkg.sv
design/fm_mmr.sv
fm_reg_file/fm_reg_file.sv
design/fm_timers.sv
design/fm_regs_top.sv
test/tb_fm_regs.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator and run; success only if the pass message shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_fm_regs \
    && ./obj_dir/Vtb_fm_regs | tee /dev/stderr | grep -qF 'All tests passed!' \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
